// ==== hdl/sramPkg.sv ====
// SRAM side definitions for the 512K x 8 asynchronous part
package sramPkg;

	// Device geometry
	localparam int ramAdrsWidth = 19;
	localparam int ramDqWidth   = 8;

	// ----------------------------------------------------------------------
	// Pin bundle toward the SRAM
	// ----------------------------------------------------------------------
	// Strobes are active low
	// Data bus split into out and enable, tristate lives in the board wrapper
	typedef struct packed {
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0]   dqOut;
		logic                    dqOe;
		logic                    oe;
		logic                    we;
		logic                    ce;
	} sramPins_t;

	// One access from the arbiter into the physical interface
	typedef struct packed {
		logic                    valid;
		logic                    read;
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0]   wd;
	} sramAccess_t;

endpackage

// ==== hdl/hostPkg.sv ====
// Host side command and response definitions
package hostPkg;

	// Number of host ports sharing the SRAM
	localparam int numPorts = 2;

	// Command as presented by a host
	// read high selects a read, low a write of wd
	typedef struct packed {
		logic                                read;
		logic [sramPkg::ramAdrsWidth-1:0]    adrs;
		logic [sramPkg::ramDqWidth-1:0]      wd;
	} hostCmd_t;

	// Response back to the host
	// Valid only while hostAck is high
	typedef struct packed {
		logic [sramPkg::ramDqWidth-1:0]      rd;
	} hostRsp_t;

endpackage

// ==== hdl/hostPort.sv ====
`timescale 1ns/100ps

module hostPort (
	input  logic                             iMemClk,
	input  logic                             iRST,
	// Host side, four-phase handshake
	input  logic                             hostReq,
	input  hostPkg::hostCmd_t                hostCmd,
	output logic                             hostAck,
	output hostPkg::hostRsp_t                hostRsp,
	// Arbiter side
	output logic                             portPend,
	output hostPkg::hostCmd_t                portCmd,
	input  logic                             portGrant,
	input  logic                             rdDone,
	input  logic [sramPkg::ramDqWidth-1:0]   rdData
);

	// Port FSM states
	typedef enum logic [1:0] {
		stIdle,
		stPend,
		stWaitRd,
		stAck
	} portState_t;

	portState_t state;

	// ----------------------------------------------------------------------
	// Handshake FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge iMemClk)
	begin
		if (iRST)
			state <= stIdle;
		else
		begin
			case (state)
				// New request from host
				stIdle:
					if (hostReq)
						state <= stPend;
				// Waiting for the arbiter
				stPend:
					if (portGrant)
						state <= portCmd.read ? stWaitRd : stAck;
				// Read issued, byte still in flight
				stWaitRd:
					if (rdDone)
						state <= stAck;
				// Hold ack until host lets go
				stAck:
					if (!hostReq)
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

	// Command held for the whole access
	always_ff @(posedge iMemClk)
	begin
		if (state == stIdle && hostReq)
			portCmd <= hostCmd;
	end

	// Returned read byte, steered here by the arbiter
	always_ff @(posedge iMemClk)
	begin
		if (rdDone)
			hostRsp.rd <= rdData;
	end

	assign portPend = (state == stPend);
	assign hostAck  = (state == stAck);

	// Ack only answers a live request from the host
	ackNeedsReq: assert property (@(posedge iMemClk) disable iff (iRST)
		$rose(hostAck) |-> hostReq);

endmodule

// ==== hdl/portArbiter.sv ====
`timescale 1ns/100ps

module portArbiter (
	input  logic                  iMemClk,
	input  logic                  iRST,
	// Host port side
	input  logic                  portPend [hostPkg::numPorts],
	input  hostPkg::hostCmd_t     portCmd [hostPkg::numPorts],
	output logic                  portGrant [hostPkg::numPorts],
	output logic                  rdDone [hostPkg::numPorts],
	output byte                   rdData,
	// Physical interface side
	output sramPkg::sramAccess_t  access,
	input  logic                  rdValid,
	input  byte                   phyRd
);

	import hostPkg::*;

	// Owner tag of one access in flight
	typedef struct packed {
		logic rd;
		logic owner;
	} rdTag_t;

	logic   lastPort;
	logic   selPort;
	logic   anyPend;
	rdTag_t rdRec [2];

	// ----------------------------------------------------------------------
	// Round-robin selection
	// ----------------------------------------------------------------------
	always_comb
	begin
		anyPend = 1'b0;
		for (int p = 0; p < numPorts; p++)
			anyPend |= portPend[p];

		// Port not served last goes first
		selPort = ~lastPort;
		if (!portPend[~lastPort])
			selPort = lastPort;

		for (int p = 0; p < numPorts; p++)
			portGrant[p] = anyPend && (selPort == p);
	end

	// Remember who was served
	always_ff @(posedge iMemClk)
	begin
		if (iRST)
			lastPort <= 1'b1;
		else if (anyPend)
			lastPort <= selPort;
	end

	// Granted command becomes this cycle's access
	always_comb
	begin
		access.valid = anyPend;
		access.read  = portCmd[selPort].read;
		access.adrs  = portCmd[selPort].adrs;
		access.wd    = portCmd[selPort].wd;
	end

	// ----------------------------------------------------------------------
	// Read ownership record
	// ----------------------------------------------------------------------
	// Stage 1 lines up with rdValid from the physical interface
	always_ff @(posedge iMemClk)
	begin
		if (iRST)
		begin
			rdRec[0] <= '0;
			rdRec[1] <= '0;
		end
		else
		begin
			rdRec[0].rd    <= access.valid && access.read;
			rdRec[0].owner <= selPort;
			rdRec[1]       <= rdRec[0];
		end
	end

	// Steer the returning byte
	always_comb
	begin
		for (int p = 0; p < numPorts; p++)
			rdDone[p] = rdValid && (rdRec[1].owner == p);
	end

	assign rdData = phyRd;

	// A granted port lets go of its request on the next cycle
	grantDropsPend0: assert property (@(posedge iMemClk) disable iff (iRST)
		portGrant[0] |=> !portPend[0]);

	grantDropsPend1: assert property (@(posedge iMemClk) disable iff (iRST)
		portGrant[1] |=> !portPend[1]);

	// Read data must match a read issued two cycles back
	rdMatchesRec: assert property (@(posedge iMemClk) disable iff (iRST)
		rdValid |-> rdRec[1].rd);

endmodule

// ==== hdl/sramPhy.sv ====
`timescale 1ns/100ps

module sramPhy (
	input  logic                  iMemClk,
	input  logic                  iRST,
	input  sramPkg::sramAccess_t  access,
	// SRAM pins
	output sramPkg::sramPins_t    pins,
	input  byte                   memDqIn,
	// Read return
	output logic                  rdValid,
	output byte                   rdData
);

	// Read sitting on the pins this cycle
	logic rdOnPins;

	// ----------------------------------------------------------------------
	// Pin register
	// ----------------------------------------------------------------------
	// WE CE OE truth table
	//   x  H  x  deselected
	//   H  L  H  output disabled
	//   H  L  L  read
	//   L  L  x  write since WE wins
	always_ff @(posedge iMemClk)
	begin
		// Address and write byte follow every access
		pins.adrs  <= access.adrs;
		pins.dqOut <= access.wd;

		if (iRST)
		begin
			pins.ce   <= 1'b1;
			pins.we   <= 1'b1;
			pins.oe   <= 1'b1;
			pins.dqOe <= 1'b0;
		end
		else if (access.valid)
		begin
			pins.ce   <= 1'b0;
			pins.we   <= access.read;
			// Read keeps our driver off the bus
			pins.oe   <= ~access.read;
			pins.dqOe <= ~access.read;
		end
		else
		begin
			pins.ce   <= 1'b1;
			pins.we   <= 1'b1;
			pins.oe   <= 1'b1;
			pins.dqOe <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// Read capture
	// ----------------------------------------------------------------------
	always_ff @(posedge iMemClk)
	begin
		if (iRST)
		begin
			rdOnPins <= 1'b0;
			rdValid  <= 1'b0;
		end
		else
		begin
			rdOnPins <= access.valid && access.read;
			rdValid  <= rdOnPins;
		end
	end

	// Sampled at the end of the pin cycle
	always_ff @(posedge iMemClk)
	begin
		if (rdOnPins)
			rdData <= memDqIn;
	end

endmodule

// ==== hdl/sramSubsystem.sv ====
`timescale 1ns/100ps

module sramSubsystem (
	input  logic                iMemClk,
	input  logic                iRST,
	// Host ports
	input  logic                hostReq [hostPkg::numPorts],
	input  hostPkg::hostCmd_t   hostCmd [hostPkg::numPorts],
	output logic                hostAck [hostPkg::numPorts],
	output hostPkg::hostRsp_t   hostRsp [hostPkg::numPorts],
	// SRAM pins
	output sramPkg::sramPins_t  pins,
	input  byte                 memDqIn
);

	import hostPkg::*;
	import sramPkg::*;

	// Port to arbiter
	logic        portPend [numPorts];
	hostCmd_t    portCmd [numPorts];
	logic        portGrant [numPorts];
	logic        rdDone [numPorts];
	byte         rdData;

	// Arbiter to physical interface
	sramAccess_t access;
	logic        rdValid;
	byte         phyRd;

	// ----------------------------------------------------------------------
	// Host ports
	// ----------------------------------------------------------------------
	for (genvar p = 0; p < numPorts; p++)
	begin : hostPortGen
		hostPort i_hostPort (
			.iMemClk   (iMemClk),
			.iRST      (iRST),
			.hostReq   (hostReq[p]),
			.hostCmd   (hostCmd[p]),
			.hostAck   (hostAck[p]),
			.hostRsp   (hostRsp[p]),
			.portPend  (portPend[p]),
			.portCmd   (portCmd[p]),
			.portGrant (portGrant[p]),
			.rdDone    (rdDone[p]),
			.rdData    (rdData)
		);
	end

	// Round-robin arbiter with read routing
	portArbiter i_portArbiter (
		.iMemClk   (iMemClk),
		.iRST      (iRST),
		.portPend  (portPend),
		.portCmd   (portCmd),
		.portGrant (portGrant),
		.rdDone    (rdDone),
		.rdData    (rdData),
		.access    (access),
		.rdValid   (rdValid),
		.phyRd     (phyRd)
	);

	// Registered pin driver
	sramPhy i_sramPhy (
		.iMemClk (iMemClk),
		.iRST    (iRST),
		.access  (access),
		.pins    (pins),
		.memDqIn (memDqIn),
		.rdValid (rdValid),
		.rdData  (phyRd)
	);

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/100ps

module tbClock (
	output logic iMemClk,
	output logic iRST
);

	// 100 ns period
	initial
	begin
		iMemClk = 1'b0;
		forever #50 iMemClk = ~iMemClk;
	end

	// Reset held for four rising edges
	initial
	begin
		iRST = 1'b1;
		repeat (4) @(posedge iMemClk);
		iRST <= 1'b0;
	end

endmodule

// ==== dv/sramModel.sv ====
`timescale 1ns/100ps

module sramModel (
	input  sramPkg::sramPins_t pins,
	output byte                memDqIn
);

	import sramPkg::*;

	logic [ramDqWidth-1:0] mem [2**ramAdrsWidth];

	// Background 0xA5 folded with every address bit
	initial
	begin
		for (int a = 0; a < 2**ramAdrsWidth; a++)
			mem[a] = 8'hA5 ^ a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
	end

	// ----------------------------------------------------------------------
	// Strobe decode
	// ----------------------------------------------------------------------
	// Write while CE and WE are low, bus driven by the controller
	always @(pins)
	begin
		if (!pins.ce && !pins.we && pins.dqOe)
			mem[pins.adrs] = pins.dqOut;
	end

	// Read path is combinational, floating bus reads as zero
	assign memDqIn = (!pins.ce && !pins.oe && pins.we) ? mem[pins.adrs] : 8'h00;

endmodule

// ==== dv/tbSramSubsystem.sv ====
`timescale 1ns/100ps

module tbSramSubsystem;

	import sramPkg::*;
	import hostPkg::*;

	// One line of the test file
	typedef struct packed {
		logic                    port;
		logic [7:0]              op;
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0]   data;
	} tbVec_t;

	localparam int timeoutCycles = 200;
	// Edges counted from the edge that raises hostReq to the one that sees hostAck
	localparam int wrLatency   = 3;
	localparam int rdLatency   = 5;
	// Ack falls one cycle after hostReq and is seen low on the second edge
	localparam int dropLatency = 2;

	logic      iMemClk;
	logic      iRST;
	logic      hostReq [numPorts];
	hostCmd_t  hostCmd [numPorts];
	logic      hostAck [numPorts];
	hostRsp_t  hostRsp [numPorts];
	sramPins_t pins;
	byte       memDqIn;

	tbVec_t    vecs[$];
	logic      prevAck [numPorts];
	int        valErrs     = 0;
	int        timeoutErrs = 0;
	int        otherErrs   = 0;
	int        latChecks   = 0;

	tbClock i_clock (.iMemClk(iMemClk), .iRST(iRST));

	sramSubsystem i_dut (
		.iMemClk (iMemClk),
		.iRST    (iRST),
		.hostReq (hostReq),
		.hostCmd (hostCmd),
		.hostAck (hostAck),
		.hostRsp (hostRsp),
		.pins    (pins),
		.memDqIn (memDqIn)
	);

	sramModel i_sram (.pins(pins), .memDqIn(memDqIn));

	// ----------------------------------------------------------------------
	// Reporting
	// ----------------------------------------------------------------------
	task automatic flagMismatch(input string msg);
		$display("[FAIL] %0t %s", $time, msg);
		valErrs++;
	endtask

	task automatic endRun();
		$display("Errors: %0d value, %0d timeout, %0d other",
			valErrs, timeoutErrs, otherErrs);
		if (valErrs == 0 && timeoutErrs == 0 && otherErrs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	// ----------------------------------------------------------------------
	// Test file
	// ----------------------------------------------------------------------
	task automatic loadVectors();
		int     fd;
		int     n;
		int     port;
		int     op;
		int     adrs;
		int     data;
		string  line;
		tbVec_t v;
		fd = $fopen("dv/sramTests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open dv/sramTests.txt");
			otherErrs++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// Skip blank lines and comments
				if (line.len() < 3 || line[0] == "#")
					continue;
				n = $sscanf(line, "%d %c %h %h", port, op, adrs, data);
				if (n != 4)
				begin
					$display("Unreadable test line: %s", line);
					otherErrs++;
					continue;
				end
				v.port = port[0];
				v.op   = op[7:0];
				v.adrs = adrs[ramAdrsWidth-1:0];
				v.data = data[ramDqWidth-1:0];
				vecs.push_back(v);
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------------------------------------
	// Host driver
	// ----------------------------------------------------------------------
	// Waits for hostAck to reach level and notes activity on the other port
	task automatic waitAck(
		input  int    p,
		input  logic  level,
		input  string what,
		output int    cycles,
		inout  logic  contended,
		output logic  timedOut
	);
		cycles = 0;
		do
		begin
			@(posedge iMemClk);
			cycles++;
			if (hostReq[1-p] || hostAck[1-p])
				contended = 1'b1;
		end
		while (hostAck[p] !== level && cycles < timeoutCycles);
		timedOut = (hostAck[p] !== level);
		if (timedOut)
		begin
			$display("Timeout on port %0d while waiting for %s", p, what);
			timeoutErrs++;
		end
	endtask

	task automatic runPort(input int p);
		tbVec_t   v;
		hostCmd_t cmd;
		int       cycles;
		int       expLat;
		logic     contended;
		logic     timedOut;
		foreach (vecs[i])
		begin
			v = vecs[i];
			if (int'(v.port) != p)
				continue;
			// Idle line with its count in the data column
			if (v.op == "I")
			begin
				repeat (v.data) @(posedge iMemClk);
				continue;
			end
			repeat ($urandom % 4) @(posedge iMemClk);
			cmd.read = (v.op == "R");
			cmd.adrs = v.adrs;
			cmd.wd   = cmd.read ? 8'h00 : v.data;
			contended = hostReq[1-p] || hostAck[1-p];
			hostReq[p] <= 1'b1;
			hostCmd[p] <= cmd;
			waitAck(p, 1'b1, "ack to rise", cycles, contended, timedOut);
			if (timedOut)
				return;
			// Latency only means something with the other port quiet
			expLat = cmd.read ? rdLatency : wrLatency;
			if (!contended)
			begin
				latChecks++;
				if (cycles != expLat)
					flagMismatch($sformatf("port %0d adrs %h acked after %0d cycles, expected %0d",
						p, v.adrs, cycles, expLat));
			end
			if (cmd.read && hostRsp[p].rd !== v.data)
				flagMismatch($sformatf("port %0d read %h returned %h, expected %h",
					p, v.adrs, hostRsp[p].rd, v.data));
			hostReq[p] <= 1'b0;
			waitAck(p, 1'b0, "ack to fall", cycles, contended, timedOut);
			if (timedOut)
				return;
			if (cycles != dropLatency)
				flagMismatch($sformatf("port %0d ack fell %0d cycles after req, expected %0d",
					p, cycles - 1, dropLatency - 1));
		end
	endtask

	// Ack must only rise under a live request
	always @(posedge iMemClk)
	begin
		for (int p = 0; p < numPorts; p++)
		begin
			if (!iRST && hostAck[p] && !prevAck[p] && !hostReq[p])
				flagMismatch($sformatf("port %0d ack rose with req low", p));
			prevAck[p] = hostAck[p];
		end
	end

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		int cycles;
		void'($urandom(93));
		for (int p = 0; p < numPorts; p++)
		begin
			hostReq[p] = 1'b0;
			hostCmd[p] = '0;
			prevAck[p] = 1'b0;
		end
		loadVectors();

		cycles = 0;
		do
		begin
			@(posedge iMemClk);
			cycles++;
		end
		while (iRST && cycles < timeoutCycles);

		if (iRST)
		begin
			$display("Timeout while waiting for reset to end");
			timeoutErrs++;
		end
		else if (vecs.size() == 0)
		begin
			$display("No test vectors were loaded");
			otherErrs++;
		end
		else
		begin
			// First edge out of reset still shows reset values
			for (int p = 0; p < numPorts; p++)
				if (hostAck[p] !== 1'b0)
					flagMismatch($sformatf("port %0d ack high after reset", p));
			if (pins.ce !== 1'b1 || pins.we !== 1'b1 || pins.oe !== 1'b1 || pins.dqOe !== 1'b0)
				flagMismatch($sformatf("pins after reset ce %b we %b oe %b dqOe %b",
					pins.ce, pins.we, pins.oe, pins.dqOe));

			fork
				runPort(0);
				runPort(1);
			join

			if (latChecks == 0)
			begin
				$display("No access ran with the other port idle, latency was never checked");
				otherErrs++;
			end
		end
		endRun();
	end

endmodule

// ==== dv/sramTests.txt ====
# port op adrs data, adrs and data in hex
# W writes data, R expects data, I idles for data cycles
0 W 00123 3C
0 R 00123 3C
0 R 00101 A5
0 I 0 18
1 I 0 30
0 W 00200 11
1 W 40200 E7
0 W 00201 22
1 R 7F0F3 A1
0 R 00200 11
1 W 40201 5A
0 R 00201 22
1 R 40200 E7
0 R 00123 3C
1 R 40201 5A
1 R 40200 E7

// ==== sramSubsystem.f ====
hdl/sramPkg.sv
hdl/hostPkg.sv
hdl/hostPort.sv
hdl/portArbiter.sv
hdl/sramPhy.sv
hdl/sramSubsystem.sv
dv/tbClock.sv
dv/sramModel.sv
dv/tbSramSubsystem.sv

// ==== Makefile ====
SHELL := /bin/bash
.SHELLFLAGS := -o pipefail -c

TOP := tbSramSubsystem
SRCS := $(shell cat sramSubsystem.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): sramSubsystem.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f sramSubsystem.f -o V$(TOP)

run: obj_dir/V$(TOP) dv/sramTests.txt
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
